// File: verilog/controlUnitPkg.sv
`default_nettype none

package controlUnitPkg;

	typedef logic [31:0] instrT;
	typedef logic [5:0] opcodeT;
	typedef logic [5:0] funcT;
	typedef logic [4:0] regAddrT;
	typedef logic [8:0] ramAddrT;     // word address into the 512 entry ram
	typedef logic [3:0] aluFlagsT;

	localparam int overflowBit = 0;   // position inside aluFlagsT

	// alu operation codes
	typedef logic [3:0] aluOpT;
	localparam aluOpT aluPass        = 4'b0000; // b input straight through
	localparam aluOpT aluAddSub      = 4'b0001;
	localparam aluOpT aluAnd         = 4'b0100;
	localparam aluOpT aluOr          = 4'b0101;
	localparam aluOpT aluNor         = 4'b0110;
	localparam aluOpT aluSrlv        = 4'b0111;
	localparam aluOpT aluSllv        = 4'b1000;
	localparam aluOpT aluSrav        = 4'b1001;
	localparam aluOpT aluLui         = 4'b1010;
	localparam aluOpT aluPcIncrement = 4'b1011;
	localparam aluOpT aluXor         = 4'b1100;
	localparam aluOpT aluCompare     = 4'b1101;

	// upper bit signed, lower bit subtract
	typedef logic [1:0] aluSignT;
	localparam aluSignT addUnsigned = 2'b00;
	localparam aluSignT subUnsigned = 2'b01;
	localparam aluSignT addSigned   = 2'b10;
	localparam aluSignT subSigned   = 2'b11;

	// compare mode, only looked at with aluCompare
	typedef logic [3:0] cmpSelT;
	localparam cmpSelT cmpSlt   = 4'b0000;
	localparam cmpSelT cmpSltu  = 4'b0001;
	localparam cmpSelT cmpSlti  = 4'b0010;
	localparam cmpSelT cmpSltiu = 4'b0011;

	// alu b input mux
	typedef logic [1:0] bSelT;
	localparam bSelT bRegister  = 2'b00;
	localparam bSelT bImmediate = 2'b01;
	localparam bSelT bMdr       = 2'b10;
	localparam bSelT bConstant  = 2'b11; // pc step

	typedef enum logic [1:0] {
		byteSize = 2'b00,
		halfSize = 2'b01,
		wordSize = 2'b11
	} memSizeT;

	typedef enum logic [2:0] {
		invalid,
		aluReg,
		aluImm,
		load,
		store
	} opClassT;

	typedef enum logic [3:0] {
		resetPc,
		fetchAddr,
		fetchRead,
		fetchWait,
		fetchLoad,
		decode,
		execute,
		overflowWrite,
		overflowTrap,
		memAddr,
		loadWait,
		loadMdr,
		loadWrite,
		storeMdr,
		storeWait
	} ctrlStateT;

	typedef struct packed {
		opClassT opClass;
		aluOpT aluOp;
		aluSignT aluSign;
		cmpSelT cmpSel;
		logic useImm;
		logic signExtend;     // imm16 and loaded data
		logic trapOnOverflow;
		memSizeT memSize;
		regAddrT rs;
		regAddrT rt;
		regAddrT rd;          // destination, whatever field it came from
	} decodedInstrT;

	typedef struct packed {
		logic clearPc;
		logic pcEnable;
		logic irEnable;
		logic marEnable;
		logic mdrEnable;
		logic regFileRw;
		regAddrT regFileRs;
		regAddrT regFileRt;
		regAddrT regFileRd;
		aluOpT aluOperation;
		aluSignT aluSign;
		cmpSelT cmpSelect;
		bSelT bSelect;
		logic mdrSelect;      // 1 takes ram data, 0 takes alu result
		logic signExtend;
		logic ramMfa;
		logic ramRw;
		memSizeT ramDataSize;
		ramAddrT ramAddress;
		logic trapSelect;
	} ctrlWordT;

endpackage

`default_nettype wire

// File: verilog/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
	input  controlUnitPkg::instrT instruction,
	output controlUnitPkg::decodedInstrT decoded
);

	controlUnitPkg::opcodeT opcode;
	controlUnitPkg::funcT func;

	assign opcode = instruction[31:26];
	assign func = instruction[5:0];

	always_comb begin
		decoded = '0;
		decoded.opClass = controlUnitPkg::invalid;
		decoded.aluOp = controlUnitPkg::aluAddSub;
		decoded.aluSign = controlUnitPkg::addUnsigned;
		decoded.cmpSel = controlUnitPkg::cmpSlt;
		decoded.memSize = controlUnitPkg::wordSize;
		decoded.rs = instruction[25:21];
		decoded.rt = instruction[20:16];
		decoded.rd = instruction[20:16]; // immediates and loads write rt

		case (opcode)
			6'b000000: begin
				decoded.opClass = controlUnitPkg::aluReg;
				decoded.rd = instruction[15:11];
				case (func)
					6'b100001: decoded.aluSign = controlUnitPkg::addUnsigned; // addu
					6'b100000: begin // add
						decoded.aluSign = controlUnitPkg::addSigned;
						decoded.trapOnOverflow = 1'b1;
					end
					6'b100011: decoded.aluSign = controlUnitPkg::subUnsigned; // subu
					6'b100010: begin // sub
						decoded.aluSign = controlUnitPkg::subSigned;
						decoded.trapOnOverflow = 1'b1;
					end
					6'b100100: decoded.aluOp = controlUnitPkg::aluAnd;
					6'b100101: decoded.aluOp = controlUnitPkg::aluOr;
					6'b100110: decoded.aluOp = controlUnitPkg::aluXor;
					6'b100111: decoded.aluOp = controlUnitPkg::aluNor;
					6'b000100: decoded.aluOp = controlUnitPkg::aluSllv;
					6'b000110: decoded.aluOp = controlUnitPkg::aluSrlv;
					6'b000111: decoded.aluOp = controlUnitPkg::aluSrav;
					6'b101010: decoded.aluOp = controlUnitPkg::aluCompare; // slt
					6'b101011: begin // sltu
						decoded.aluOp = controlUnitPkg::aluCompare;
						decoded.cmpSel = controlUnitPkg::cmpSltu;
					end
					default: decoded.opClass = controlUnitPkg::invalid;
				endcase
			end

			// immediates
			6'b001000, 6'b001001: begin // addi, addiu
				decoded.opClass = controlUnitPkg::aluImm;
				decoded.aluSign = controlUnitPkg::addSigned;
				decoded.useImm = 1'b1;
				decoded.signExtend = 1'b1;
				decoded.trapOnOverflow = !opcode[0]; // only addi traps
			end
			6'b001100, 6'b001101, 6'b001110: begin // andi, ori, xori
				decoded.opClass = controlUnitPkg::aluImm;
				decoded.useImm = 1'b1;
				case (opcode[1:0])
					2'b00: decoded.aluOp = controlUnitPkg::aluAnd;
					2'b01: decoded.aluOp = controlUnitPkg::aluOr;
					default: decoded.aluOp = controlUnitPkg::aluXor;
				endcase
			end
			6'b001111: begin // lui, destination in the rs slot
				decoded.opClass = controlUnitPkg::aluImm;
				decoded.aluOp = controlUnitPkg::aluLui;
				decoded.useImm = 1'b1;
				decoded.rd = instruction[25:21];
			end
			6'b001010, 6'b001011: begin // slti, sltiu
				decoded.opClass = controlUnitPkg::aluImm;
				decoded.aluOp = controlUnitPkg::aluCompare;
				decoded.useImm = 1'b1;
				decoded.signExtend = 1'b1;
				decoded.cmpSel = opcode[0] ? controlUnitPkg::cmpSltiu : controlUnitPkg::cmpSlti;
			end

			// loads, bit 2 of the opcode marks the unsigned forms
			6'b100011, 6'b100001, 6'b100101, 6'b100000, 6'b100100: begin
				decoded.opClass = controlUnitPkg::load;
				decoded.useImm = 1'b1;
				decoded.signExtend = !opcode[2];
				case (opcode[1:0])
					2'b11: decoded.memSize = controlUnitPkg::wordSize;
					2'b01: decoded.memSize = controlUnitPkg::halfSize;
					default: decoded.memSize = controlUnitPkg::byteSize;
				endcase
			end

			// stores, each with its own size
			6'b101011, 6'b101001, 6'b101000: begin
				decoded.opClass = controlUnitPkg::store;
				decoded.useImm = 1'b1;
				decoded.signExtend = 1'b1;
				case (opcode[1:0])
					2'b11: decoded.memSize = controlUnitPkg::wordSize;
					2'b01: decoded.memSize = controlUnitPkg::halfSize;
					default: decoded.memSize = controlUnitPkg::byteSize;
				endcase
			end

			default: decoded.opClass = controlUnitPkg::invalid;
		endcase
	end

	// the sequencer branches on opClass, an x here would stall it silently
	always_comb begin
		opClassKnown: assert final (!$isunknown(decoded.opClass));
	end

endmodule

`default_nettype wire

// File: verilog/controlSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module controlSequencer (
	input  logic Clk,
	input  logic arstN,
	input  controlUnitPkg::decodedInstrT decoded,
	input  controlUnitPkg::aluFlagsT aluFlags,
	input  logic ramMfc,
	output controlUnitPkg::ctrlStateT state
);

	controlUnitPkg::ctrlStateT nextState;
	logic overflow;
	logic inWait;

	assign overflow = aluFlags[controlUnitPkg::overflowBit];

	// states that hold ramMfa and park until the memory finishes
	assign inWait = state inside {
		controlUnitPkg::fetchWait,
		controlUnitPkg::loadWait,
		controlUnitPkg::storeWait
	};

	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			state <= controlUnitPkg::resetPc;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state; // wait states hold by default
		case (state)
			controlUnitPkg::resetPc: nextState = controlUnitPkg::fetchAddr;

			// fetch
			controlUnitPkg::fetchAddr: nextState = controlUnitPkg::fetchRead;
			controlUnitPkg::fetchRead: nextState = controlUnitPkg::fetchWait;
			controlUnitPkg::fetchWait: begin
				if (ramMfc) begin
					nextState = controlUnitPkg::fetchLoad;
				end
			end
			controlUnitPkg::fetchLoad: nextState = controlUnitPkg::decode;

			controlUnitPkg::decode: begin
				case (decoded.opClass)
					controlUnitPkg::aluReg,
					controlUnitPkg::aluImm: nextState = controlUnitPkg::execute;
					controlUnitPkg::load,
					controlUnitPkg::store: nextState = controlUnitPkg::memAddr;
					default: nextState = controlUnitPkg::fetchAddr; // not decoded, refetch
				endcase
			end

			controlUnitPkg::execute: begin
				if (!decoded.trapOnOverflow) begin
					nextState = controlUnitPkg::fetchAddr;
				end else if (overflow) begin
					nextState = controlUnitPkg::overflowTrap;
				end else begin
					nextState = controlUnitPkg::overflowWrite;
				end
			end
			controlUnitPkg::overflowWrite: nextState = controlUnitPkg::fetchAddr;
			controlUnitPkg::overflowTrap: nextState = controlUnitPkg::fetchWait; // trap fetch

			// memory access
			controlUnitPkg::memAddr: begin
				if (decoded.opClass == controlUnitPkg::load) begin
					nextState = controlUnitPkg::loadWait;
				end else begin
					nextState = controlUnitPkg::storeMdr;
				end
			end
			controlUnitPkg::loadWait: begin
				if (ramMfc) begin
					nextState = controlUnitPkg::loadMdr;
				end
			end
			controlUnitPkg::loadMdr: nextState = controlUnitPkg::loadWrite;
			controlUnitPkg::loadWrite: nextState = controlUnitPkg::fetchAddr;
			controlUnitPkg::storeMdr: nextState = controlUnitPkg::storeWait;
			controlUnitPkg::storeWait: begin
				if (ramMfc) begin
					nextState = controlUnitPkg::fetchAddr;
				end
			end

			default: nextState = controlUnitPkg::resetPc; // unused code
		endcase
	end

	// memory still busy, nothing may move
	waitHeld: assert property (@(posedge Clk) disable iff (!arstN)
		inWait && !ramMfc |=> $stable(state));

	// a trap fetch needs a trapping instruction that overflowed in execute
	trapEntry: assert property (@(posedge Clk) disable iff (!arstN)
		state == controlUnitPkg::overflowTrap |->
			$past(state) == controlUnitPkg::execute &&
			$past(decoded.trapOnOverflow) && $past(overflow));

endmodule

`default_nettype wire

// File: verilog/controlOutputs.sv
`timescale 1ns/1ps
`default_nettype none

module controlOutputs #(
	parameter controlUnitPkg::ramAddrT trapAddress = 9'd448
) (
	input  controlUnitPkg::ctrlStateT state,
	input  controlUnitPkg::decodedInstrT decoded,
	output controlUnitPkg::ctrlWordT ctrl
);

	logic useRegs;

	// execute and memory states address the register file
	assign useRegs = state inside {
		controlUnitPkg::execute,
		controlUnitPkg::overflowWrite,
		controlUnitPkg::memAddr,
		controlUnitPkg::loadWait,
		controlUnitPkg::loadMdr,
		controlUnitPkg::loadWrite,
		controlUnitPkg::storeMdr,
		controlUnitPkg::storeWait
	};

	always_comb begin
		ctrl = '0;
		if (useRegs) begin
			ctrl.regFileRs = decoded.rs;
			ctrl.regFileRt = decoded.rt;
			ctrl.regFileRd = decoded.rd;
		end

		case (state)
			controlUnitPkg::resetPc: ctrl.clearPc = 1'b1;

			controlUnitPkg::fetchAddr: begin
				ctrl.marEnable = 1'b1; // pc into mar
				ctrl.aluOperation = controlUnitPkg::aluPass;
				ctrl.bSelect = controlUnitPkg::bConstant;
			end
			controlUnitPkg::fetchRead: begin
				ctrl.pcEnable = 1'b1; // pc + 4 while the read starts
				ctrl.aluOperation = controlUnitPkg::aluPcIncrement;
				ctrl.bSelect = controlUnitPkg::bConstant;
				ctrl.ramMfa = 1'b1;
				ctrl.ramDataSize = controlUnitPkg::wordSize;
			end
			controlUnitPkg::fetchWait: begin
				ctrl.ramMfa = 1'b1;
				ctrl.ramDataSize = controlUnitPkg::wordSize;
			end
			controlUnitPkg::fetchLoad: ctrl.irEnable = 1'b1;

			controlUnitPkg::execute,
			controlUnitPkg::overflowWrite: begin
				ctrl.aluOperation = decoded.aluOp;
				ctrl.aluSign = decoded.aluSign;
				ctrl.cmpSelect = decoded.cmpSel;
				ctrl.signExtend = decoded.signExtend;
				ctrl.bSelect = decoded.useImm ? controlUnitPkg::bImmediate
					: controlUnitPkg::bRegister;
				// trapping forms write one cycle later, once the flag is known
				ctrl.regFileRw = (state == controlUnitPkg::overflowWrite) ||
					!decoded.trapOnOverflow;
			end
			controlUnitPkg::overflowTrap: begin
				ctrl.trapSelect = 1'b1;
				ctrl.ramMfa = 1'b1;
				ctrl.ramAddress = trapAddress;
				ctrl.ramDataSize = controlUnitPkg::wordSize;
			end

			controlUnitPkg::memAddr: begin
				ctrl.marEnable = 1'b1; // base + offset
				ctrl.aluOperation = decoded.aluOp;
				ctrl.aluSign = decoded.aluSign;
				ctrl.bSelect = controlUnitPkg::bImmediate;
				ctrl.signExtend = decoded.signExtend;
			end
			controlUnitPkg::loadWait: begin
				ctrl.ramMfa = 1'b1;
				ctrl.ramDataSize = decoded.memSize;
				ctrl.signExtend = decoded.signExtend;
			end
			controlUnitPkg::loadMdr: begin
				ctrl.mdrEnable = 1'b1;
				ctrl.mdrSelect = 1'b1; // ram data
				ctrl.ramDataSize = decoded.memSize;
				ctrl.signExtend = decoded.signExtend;
			end
			controlUnitPkg::loadWrite: begin
				ctrl.regFileRw = 1'b1;
				ctrl.aluOperation = controlUnitPkg::aluPass;
				ctrl.bSelect = controlUnitPkg::bMdr;
				ctrl.signExtend = decoded.signExtend;
			end
			controlUnitPkg::storeMdr: begin
				ctrl.mdrEnable = 1'b1; // rt through the alu, mdrSelect stays 0
				ctrl.aluOperation = controlUnitPkg::aluPass;
				ctrl.bSelect = controlUnitPkg::bRegister;
			end
			controlUnitPkg::storeWait: begin
				ctrl.ramMfa = 1'b1;
				ctrl.ramRw = 1'b1;
				ctrl.ramDataSize = decoded.memSize;
			end

			default: ctrl.clearPc = 1'b0; // decode drives nothing
		endcase
	end

	// a write-back never overlaps a memory access in any state
	always_comb begin
		rwMfaExclusive: assert final (!(ctrl.regFileRw && ctrl.ramMfa));
	end

endmodule

`default_nettype wire

// File: verilog/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit #(
	parameter controlUnitPkg::ramAddrT trapAddress = 9'd448
) (
	input  logic Clk,
	input  logic arstN,
	input  controlUnitPkg::instrT instruction, // from the ir
	input  controlUnitPkg::aluFlagsT aluFlags,
	input  logic ramMfc,
	output controlUnitPkg::ctrlWordT ctrl
);

	controlUnitPkg::decodedInstrT decoded;
	controlUnitPkg::ctrlStateT state;

	instrDecoder uDecoder (
		.instruction(instruction),
		.decoded(decoded)
	);

	controlSequencer uSequencer (
		.Clk(Clk),
		.arstN(arstN),
		.decoded(decoded),
		.aluFlags(aluFlags),
		.ramMfc(ramMfc),
		.state(state)
	);

	// trap vector set here
	controlOutputs #(
		.trapAddress(trapAddress)
	) uOutputs (
		.state(state),
		.decoded(decoded),
		.ctrl(ctrl)
	);

endmodule

`default_nettype wire

// File: sim/controlUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnitTb;

	localparam int numTests = 35;
	localparam int cyclesPerTest = 40;

	// one bit per single-bit control, used to build expected words
	localparam logic [9:0] fClr = 10'd1;
	localparam logic [9:0] fPc = 10'd2;
	localparam logic [9:0] fIr = 10'd4;
	localparam logic [9:0] fMar = 10'd8;
	localparam logic [9:0] fMdr = 10'd16;
	localparam logic [9:0] fRw = 10'd32;
	localparam logic [9:0] fMdrSel = 10'd64;
	localparam logic [9:0] fMfa = 10'd128;
	localparam logic [9:0] fRamRw = 10'd256;
	localparam logic [9:0] fTrap = 10'd512;

	localparam controlUnitPkg::instrT badOpcode = 32'hfc00_0000;

	logic Clk;
	logic arstN;
	controlUnitPkg::instrT instruction;
	controlUnitPkg::aluFlagsT aluFlags;
	logic ramMfc;
	controlUnitPkg::ctrlWordT ctrl;

	integer seed;
	int testErrors;
	int testsRun;
	int testsFailed;
	string curTest;

	controlUnit DUT (
		.Clk(Clk),
		.arstN(arstN),
		.instruction(instruction),
		.aluFlags(aluFlags),
		.ramMfc(ramMfc),
		.ctrl(ctrl)
	);

	always #4 Clk = ~Clk;

	task automatic checkCtrl(input controlUnitPkg::ctrlWordT got, exp, mask, input string what);
		if ((got & mask) !== (exp & mask)) begin
			testErrors++;
			$display("Mismatch at %0t: %s in %s, got %h expected %h", $time, what, curTest,
				got & mask, exp & mask);
		end
	endtask

	task automatic checkAluOp(input controlUnitPkg::aluOpT got, exp, input string what);
		if (got !== exp) begin
			testErrors++;
			$display("Mismatch at %0t: %s in %s, got %b expected %b", $time, what, curTest,
				got, exp);
		end
	endtask

	task automatic checkMemSize(input controlUnitPkg::memSizeT got, exp, input string what);
		if (got !== exp) begin
			testErrors++;
			$display("Mismatch at %0t: %s in %s, got %b expected %b", $time, what, curTest,
				got, exp);
		end
	endtask

	function automatic controlUnitPkg::ctrlWordT flagWord(input logic [9:0] f);
		controlUnitPkg::ctrlWordT w;
		w = '0;
		w.clearPc = f[0];
		w.pcEnable = f[1];
		w.irEnable = f[2];
		w.marEnable = f[3];
		w.mdrEnable = f[4];
		w.regFileRw = f[5];
		w.mdrSelect = f[6];
		w.ramMfa = f[7];
		w.ramRw = f[8];
		w.trapSelect = f[9];
		return w;
	endfunction

	// full control word of an alu write cycle
	function automatic controlUnitPkg::ctrlWordT execWord(input controlUnitPkg::instrT ins,
			input controlUnitPkg::regAddrT dest, input controlUnitPkg::aluOpT op,
			input controlUnitPkg::aluSignT sg, input controlUnitPkg::cmpSelT cs,
			input logic useImm, input logic sext, input logic rw);
		controlUnitPkg::ctrlWordT w;
		w = '0;
		w.regFileRw = rw;
		w.regFileRs = ins[25:21];
		w.regFileRt = ins[20:16];
		w.regFileRd = dest;
		w.aluOperation = op;
		w.aluSign = sg;
		w.cmpSelect = cs;
		w.bSelect = useImm ? controlUnitPkg::bImmediate : controlUnitPkg::bRegister;
		w.signExtend = sext;
		return w;
	endfunction

	function automatic controlUnitPkg::instrT rType(input controlUnitPkg::funcT f);
		return {6'b000000, 15'($random(seed)), 5'd0, f}; // rs rt rd random
	endfunction

	function automatic controlUnitPkg::instrT iType(input controlUnitPkg::opcodeT op);
		return {op, 26'($random(seed))};
	endfunction

	task automatic expectFlags(input logic [9:0] f, input string what);
		checkCtrl(ctrl, flagWord(f), flagWord('1), what);
	endtask

	task automatic nextCycle;
		@(negedge Clk); // outputs settled since the rising edge
	endtask

	task automatic startTest(input string name);
		curTest = name;
		testErrors = 0;
	endtask

	task automatic endTest;
		testsRun++;
		if (testErrors == 0) begin
			$display("pass: %s", curTest);
		end else begin
			testsFailed++;
			$display("FAILED: %s with %0d errors", curTest, testErrors);
		end
	endtask

	// memory model, finishes after 0 to 3 busy cycles
	task automatic waitMemory;
		int delay;
		controlUnitPkg::ctrlWordT held;
		held = ctrl;
		delay = {$random(seed)} % 4;
		ramMfc = 1'b0;
		repeat (delay) begin
			nextCycle();
			checkCtrl(ctrl, held, '1, "output held while memory busy");
		end
		ramMfc = 1'b1;
		nextCycle();
		ramMfc = 1'b0;
	endtask

	// starts with fetchWait sampled, ends with decode sampled
	task automatic fetchTail(input controlUnitPkg::instrT ins);
		expectFlags(fMfa, "fetch wait");
		waitMemory();
		expectFlags(fIr, "ir load right after ramMfc");
		instruction = ins; // ir contents from here on
		nextCycle();
		expectFlags('0, "decode");
	endtask

	// starts with fetchAddr sampled
	task automatic fetchInstr(input controlUnitPkg::instrT ins);
		nextCycle();
		expectFlags(fPc | fMfa, "fetch read");
		checkMemSize(ctrl.ramDataSize, controlUnitPkg::wordSize, "fetch size");
		nextCycle();
		fetchTail(ins);
	endtask

	task automatic aluTest(input string name, input controlUnitPkg::instrT ins,
			input controlUnitPkg::regAddrT dest, input controlUnitPkg::aluOpT op,
			input controlUnitPkg::aluSignT sg, input controlUnitPkg::cmpSelT cs,
			input logic useImm, input logic sext, input logic traps, input logic ovf);
		controlUnitPkg::ctrlWordT trapWord;
		controlUnitPkg::ctrlWordT mask;
		startTest(name);
		aluFlags = {3'($random(seed)), ovf}; // only bit 0 may matter
		fetchInstr(ins);
		nextCycle();
		checkCtrl(ctrl, execWord(ins, dest, op, sg, cs, useImm, sext, !traps), '1, "execute");
		checkAluOp(ctrl.aluOperation, op, "execute alu op");
		if (traps && !ovf) begin
			nextCycle();
			checkCtrl(ctrl, execWord(ins, dest, op, sg, cs, useImm, sext, 1'b1), '1,
				"write after overflow check");
		end else if (traps) begin
			nextCycle();
			trapWord = flagWord(fTrap | fMfa);
			trapWord.ramAddress = 9'd448;
			mask = flagWord('1);
			mask.ramAddress = '1;
			checkCtrl(ctrl, trapWord, mask, "trap fetch");
			nextCycle();
			fetchTail(badOpcode);
		end
		nextCycle();
		expectFlags(fMar, "back to fetch");
		aluFlags = '0;
		endTest();
	endtask

	task automatic regTest(input string name, input controlUnitPkg::funcT f,
			input controlUnitPkg::aluOpT op, input controlUnitPkg::aluSignT sg,
			input controlUnitPkg::cmpSelT cs, input logic traps, input logic ovf);
		controlUnitPkg::instrT ins;
		ins = rType(f);
		aluTest(name, ins, ins[15:11], op, sg, cs, 1'b0, 1'b0, traps, ovf);
	endtask

	task automatic immTest(input string name, input controlUnitPkg::opcodeT opc,
			input controlUnitPkg::aluOpT op, input controlUnitPkg::aluSignT sg,
			input controlUnitPkg::cmpSelT cs, input logic sext, input logic traps,
			input logic ovf);
		controlUnitPkg::instrT ins;
		controlUnitPkg::regAddrT dest;
		ins = iType(opc);
		dest = (opc == 6'b001111) ? ins[25:21] : ins[20:16]; // lui writes the rs slot
		aluTest(name, ins, dest, op, sg, cs, 1'b1, sext, traps, ovf);
	endtask

	task automatic memTest(input string name, input controlUnitPkg::opcodeT opc,
			input logic isLoad, input controlUnitPkg::memSizeT size, input logic sext);
		controlUnitPkg::instrT ins;
		controlUnitPkg::ctrlWordT w;
		controlUnitPkg::ctrlWordT mask;
		startTest(name);
		ins = iType(opc);
		fetchInstr(ins);
		nextCycle();
		w = flagWord(fMar);
		w.signExtend = sext;
		mask = flagWord('1);
		mask.signExtend = 1'b1;
		checkCtrl(ctrl, w, mask, "address into mar");
		if (isLoad) begin
			nextCycle();
			expectFlags(fMfa, "load wait");
			checkMemSize(ctrl.ramDataSize, size, "load size");
			waitMemory();
			expectFlags(fMdr | fMdrSel, "mdr from ram");
			nextCycle();
			w = flagWord(fRw);
			w.regFileRs = ins[25:21];
			w.regFileRt = ins[20:16];
			w.regFileRd = ins[20:16];
			w.bSelect = controlUnitPkg::bMdr;
			w.signExtend = sext;
			checkCtrl(ctrl, w, '1, "load write");
			nextCycle();
		end else begin
			nextCycle();
			expectFlags(fMdr, "mdr from register");
			nextCycle();
			expectFlags(fMfa | fRamRw, "store wait");
			checkMemSize(ctrl.ramDataSize, size, "store size");
			waitMemory();
		end
		expectFlags(fMar, "back to fetch");
		endTest();
	endtask

	task automatic invalidTest(input string name, input controlUnitPkg::instrT ins);
		startTest(name);
		fetchInstr(ins);
		nextCycle();
		expectFlags(fMar, "fetch right after decode");
		endTest();
	endtask

	initial begin
		Clk = 1'b0;
		arstN = 1'b0;
		instruction = '0;
		aluFlags = '0;
		ramMfc = 1'b0;
		seed = 32'h452f622f;
		testsRun = 0;
		testsFailed = 0;

		startTest("reset and first fetch");
		repeat (2) begin
			nextCycle();
			expectFlags(fClr, "in reset");
		end
		arstN = 1'b1;
		nextCycle();
		expectFlags(fMar, "fetch address");
		fetchInstr(badOpcode);
		nextCycle();
		expectFlags(fMar, "back to fetch");
		endTest();

		regTest("addu", 6'b100001, controlUnitPkg::aluAddSub, 2'b00, 4'b0000, 1'b0, 1'b0);
		regTest("add", 6'b100000, controlUnitPkg::aluAddSub, 2'b10, 4'b0000, 1'b1, 1'b0);
		regTest("subu", 6'b100011, controlUnitPkg::aluAddSub, 2'b01, 4'b0000, 1'b0, 1'b0);
		regTest("sub", 6'b100010, controlUnitPkg::aluAddSub, 2'b11, 4'b0000, 1'b1, 1'b0);
		regTest("and", 6'b100100, controlUnitPkg::aluAnd, 2'b00, 4'b0000, 1'b0, 1'b0);
		regTest("or", 6'b100101, controlUnitPkg::aluOr, 2'b00, 4'b0000, 1'b0, 1'b0);
		regTest("xor", 6'b100110, controlUnitPkg::aluXor, 2'b00, 4'b0000, 1'b0, 1'b0);
		regTest("nor", 6'b100111, controlUnitPkg::aluNor, 2'b00, 4'b0000, 1'b0, 1'b0);
		regTest("sllv", 6'b000100, controlUnitPkg::aluSllv, 2'b00, 4'b0000, 1'b0, 1'b0);
		regTest("srlv", 6'b000110, controlUnitPkg::aluSrlv, 2'b00, 4'b0000, 1'b0, 1'b0);
		regTest("srav", 6'b000111, controlUnitPkg::aluSrav, 2'b00, 4'b0000, 1'b0, 1'b0);
		regTest("slt", 6'b101010, controlUnitPkg::aluCompare, 2'b00, 4'b0000, 1'b0, 1'b0);
		regTest("sltu", 6'b101011, controlUnitPkg::aluCompare, 2'b00, 4'b0001, 1'b0, 1'b0);

		immTest("addi", 6'b001000, controlUnitPkg::aluAddSub, 2'b10, 4'b0000, 1, 1, 0);
		immTest("addiu", 6'b001001, controlUnitPkg::aluAddSub, 2'b10, 4'b0000, 1, 0, 0);
		immTest("andi", 6'b001100, controlUnitPkg::aluAnd, 2'b00, 4'b0000, 0, 0, 0);
		immTest("ori", 6'b001101, controlUnitPkg::aluOr, 2'b00, 4'b0000, 0, 0, 0);
		immTest("xori", 6'b001110, controlUnitPkg::aluXor, 2'b00, 4'b0000, 0, 0, 0);
		immTest("lui", 6'b001111, controlUnitPkg::aluLui, 2'b00, 4'b0000, 0, 0, 0);
		immTest("slti", 6'b001010, controlUnitPkg::aluCompare, 2'b00, 4'b0010, 1, 0, 0);
		immTest("sltiu", 6'b001011, controlUnitPkg::aluCompare, 2'b00, 4'b0011, 1, 0, 0);

		// overflow flag set, trap fetch instead of a write
		regTest("add overflow", 6'b100000, controlUnitPkg::aluAddSub, 2'b10, 4'b0000, 1, 1);
		regTest("sub overflow", 6'b100010, controlUnitPkg::aluAddSub, 2'b11, 4'b0000, 1, 1);
		immTest("addi overflow", 6'b001000, controlUnitPkg::aluAddSub, 2'b10, 4'b0000, 1, 1, 1);

		memTest("lw", 6'b100011, 1'b1, controlUnitPkg::wordSize, 1'b1);
		memTest("lh", 6'b100001, 1'b1, controlUnitPkg::halfSize, 1'b1);
		memTest("lhu", 6'b100101, 1'b1, controlUnitPkg::halfSize, 1'b0);
		memTest("lb", 6'b100000, 1'b1, controlUnitPkg::byteSize, 1'b1);
		memTest("lbu", 6'b100100, 1'b1, controlUnitPkg::byteSize, 1'b0);
		memTest("sw", 6'b101011, 1'b0, controlUnitPkg::wordSize, 1'b1);
		memTest("sh", 6'b101001, 1'b0, controlUnitPkg::halfSize, 1'b1);
		memTest("sb", 6'b101000, 1'b0, controlUnitPkg::byteSize, 1'b1);

		invalidTest("invalid opcode", badOpcode);
		invalidTest("invalid function", rType(6'b111111));

		$display("%0d tests run, %0d failed", testsRun, testsFailed);
		if (testsFailed == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	// generous bound per test, a stuck wait state lands here
	initial begin
		repeat (numTests * cyclesPerTest) @(posedge Clk);
		$display("Timeout: the control unit stopped advancing in test %s", curTest);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: controlUnit.f
verilog/controlUnitPkg.sv
verilog/instrDecoder.sv
verilog/controlSequencer.sv
verilog/controlOutputs.sv
verilog/controlUnit.sv
sim/controlUnitTb.sv
